// ==== ex_stage.f ====
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_operand_if.sv
hdl/operand_select.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/div_unit.sv
hdl/result_buffer.sv
hdl/ex_stage.sv
tests/ex_stage_chk.sv
tests/ex_stage_tb.sv

// ==== tests/ex_stage_tb.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_stage_tb;
    import ex_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_DIVIDES = 21;
    localparam int DIV_LIMIT   = 40;
    // Reset, ALU, forwarding, branches, stall and flush, divides, margin
    localparam int RUN_CYCLES  = 3 + 30 + 12 + 45 + 25 + NUM_DIVIDES * DIV_LIMIT + 100;

    logic     clk;
    logic     rst;
    logic     valid, use_imm, wen, stall, flush;
    alu_op_e  op;
    res_sel_e res_sel;
    raddr_t   rs1_addr, rs2_addr, waddr;
    word_t    rs1_data, rs2_data, imm, pc;
    logic     fwd0_wen, fwd0_load, fwd1_wen, fwd1_load;
    raddr_t   fwd0_addr, fwd1_addr;
    word_t    fwd0_data, fwd1_data;
    logic     branch_taken, stall_req, res_valid, res_wen;
    word_t    branch_target, res_wdata;
    raddr_t   res_waddr;

    logic [31:0] lfsr_state = 32'h6a71;
    int          errors = 0;
    int          checks = 0;

    ex_stage i_dut (
        .clk (clk), .rst (rst),
        .valid_i (valid), .op_i (op), .res_sel_i (res_sel),
        .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr),
        .rs1_data_i (rs1_data), .rs2_data_i (rs2_data),
        .imm_i (imm), .pc_i (pc), .use_imm_i (use_imm),
        .waddr_i (waddr), .wen_i (wen),
        .fwd0_wen_i (fwd0_wen), .fwd0_load_i (fwd0_load),
        .fwd0_addr_i (fwd0_addr), .fwd0_data_i (fwd0_data),
        .fwd1_wen_i (fwd1_wen), .fwd1_load_i (fwd1_load),
        .fwd1_addr_i (fwd1_addr), .fwd1_data_i (fwd1_data),
        .stall_i (stall), .flush_i (flush),
        .branch_taken_o (branch_taken), .branch_target_o (branch_target),
        .stall_req_o (stall_req), .res_valid_o (res_valid), .res_wen_o (res_wen),
        .res_waddr_o (res_waddr), .res_wdata_o (res_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic res_sel_e res_class(input alu_op_e o);
        case (o)
            OP_OR, OP_AND, OP_XOR, OP_NOR, OP_ORN, OP_ANDN: return RES_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:                         return RES_SHIFT;
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU:                return RES_ARITH;
            default:                                        return RES_MOVE;
        endcase
    endfunction

    function automatic word_t alu_model(input alu_op_e o, input word_t a, input word_t b,
                                        input word_t p);
        logic [`EX_SHAMT_W-1:0] sh;
        sh = b[`EX_SHAMT_W-1:0];
        case (o)
            OP_OR:    return a | b;
            OP_AND:   return a & b;
            OP_XOR:   return a ^ b;
            OP_NOR:   return ~(a | b);
            OP_ORN:   return a | ~b;
            OP_ANDN:  return a & ~b;
            OP_SLL:   return a << sh;
            OP_SRL:   return a >> sh;
            OP_SRA:   return word_t'($signed(a) >>> sh);
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            OP_LUI:   return b;
            OP_PCADD: return p + b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_model(input alu_op_e o, input word_t a, input word_t b);
        case (o)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGE:  return $signed(a) >= $signed(b);
            OP_BLTU: return a < b;
            OP_BGEU: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    // Magnitude divide, quotient toward zero, remainder follows dividend
    function automatic word_t div_model(input alu_op_e o, input word_t a, input word_t b);
        logic  sgn, an, bn;
        word_t am, bm, q, r;
        sgn = (o == OP_DIV) || (o == OP_MOD);
        if (b == '0) begin
            q = '1;
            r = a;
        end else begin
            an = sgn && a[31];
            bn = sgn && b[31];
            am = an ? -a : a;
            bm = bn ? -b : b;
            q  = am / bm;
            r  = am % bm;
            if (an != bn) q = -q;
            if (an) r = -r;
        end
        return (o == OP_DIV || o == OP_DIVU) ? q : r;
    endfunction

    task automatic init_inputs();
        rst = 1'b1;
        valid = 1'b0;
        op = OP_NOP;
        res_sel = RES_NONE;
        {rs1_addr, rs2_addr, waddr, fwd0_addr, fwd1_addr} = '0;
        {rs1_data, rs2_data, imm, pc, fwd0_data, fwd1_data} = '0;
        {use_imm, wen, stall, flush, fwd0_wen, fwd0_load, fwd1_wen, fwd1_load} = '0;
    endtask

    task automatic set_fwd(input int port, input logic w, input logic ld, input raddr_t ad,
                           input word_t d);
        if (port == 0) begin
            fwd0_wen = w;
            fwd0_load = ld;
            fwd0_addr = ad;
            fwd0_data = d;
        end else begin
            fwd1_wen = w;
            fwd1_load = ld;
            fwd1_addr = ad;
            fwd1_data = d;
        end
    endtask

    // pc, waddr and wen are random per instruction
    task automatic drive_instr(input alu_op_e o, input res_sel_e sel, input word_t a,
                               input word_t b, input word_t im, input logic ui);
        valid = 1'b1;
        op = o;
        res_sel = sel;
        rs1_data = a;
        rs2_data = b;
        imm = im;
        use_imm = ui;
        pc = rand_bits(30) << 2;
        waddr = raddr_t'(rand_bits(`EX_RADDR_W));
        wen = lfsr_bit();
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_result(input word_t exp);
        step();
        check_eq("res_valid_o", res_valid, 1'b1);
        check_eq("res_wen_o", res_wen, wen);
        check_eq("res_waddr_o", res_waddr, waddr);
        check_eq("res_wdata_o", res_wdata, exp);
    endtask

    task automatic wait_div_done();
        int n;
        n = 0;
        while (stall_req && n < DIV_LIMIT) begin
            step();
            n++;
        end
        if (stall_req) begin
            errors++;
            $display("Divider kept stall_req_o high for more than %0d cycles", DIV_LIMIT);
        end
    endtask

    task automatic alu_ops_test();
        alu_op_e o;
        word_t   a, b, im;
        for (int k = int'(OP_OR); k <= int'(OP_PCADD); k++) begin
            for (int u = 0; u < 2; u++) begin
                o = alu_op_e'(k);
                a = rand_bits(32);
                b = rand_bits(32);
                im = rand_bits(32);
                drive_instr(o, res_class(o), a, b, im, u == 1);
                check_result(alu_model(o, a, (u == 1) ? im : b, pc));
            end
        end
    endtask

    task automatic forwarding_test();
        word_t d0, d1, r1, r2;
        d0 = rand_bits(32);
        d1 = rand_bits(32);
        r1 = rand_bits(32);
        r2 = rand_bits(32);
        rs1_addr = 5'd3;
        rs2_addr = 5'd7;
        drive_instr(OP_ADD, RES_ARITH, r1, r2, 32'd0, 1'b0);
        check_result(r1 + r2);
        set_fwd(0, 1'b1, 1'b1, 5'd3, d0);
        check_result(d0 + r2);
        set_fwd(1, 1'b1, 1'b1, 5'd3, d1);
        check_result(d1 + r2);
        // Non-load entry on port 1 falls back to port 0
        set_fwd(1, 1'b1, 1'b0, 5'd3, d1);
        check_result(d0 + r2);
        set_fwd(0, 1'b1, 1'b1, 5'd7, d0);
        set_fwd(1, 1'b1, 1'b1, 5'd3, d1);
        check_result(d1 + d0);
        set_fwd(0, 1'b0, 1'b1, 5'd7, d0);
        check_result(d1 + r2);
        set_fwd(1, 1'b1, 1'b1, 5'd4, d1);
        check_result(r1 + r2);
        rs1_addr = 5'd0;
        rs2_addr = 5'd0;
        set_fwd(0, 1'b1, 1'b1, 5'd0, d0);
        set_fwd(1, 1'b1, 1'b1, 5'd0, d1);
        check_result(r1 + r2);
        // BEQ sees forwarded rs2, not the immediate
        rs1_addr = 5'd3;
        rs2_addr = 5'd9;
        set_fwd(0, 1'b0, 1'b0, 5'd0, '0);
        set_fwd(1, 1'b1, 1'b1, 5'd9, r1);
        drive_instr(OP_BEQ, RES_NONE, r1, ~r1, rand_bits(32), 1'b1);
        #1;
        check_eq("branch_taken_o", branch_taken, 1'b1);
        check_eq("branch_target_o", branch_target, pc + imm);
        step();
        set_fwd(1, 1'b1, 1'b0, 5'd9, r1);
        #1;
        check_eq("branch_taken_o", branch_taken, 1'b0);
        step();
        set_fwd(1, 1'b0, 1'b0, 5'd0, '0);
    endtask

    task automatic branch_test();
        word_t   va [6] = '{32'd5, 32'h7fffffff, 32'h80000000, 32'd1, 32'hffffffff, 32'h80000000};
        word_t   vb [6] = '{32'd5, 32'h80000000, 32'h7fffffff, 32'd2, 32'd0, 32'h80000000};
        alu_op_e o;
        for (int k = int'(OP_BEQ); k <= int'(OP_BGEU); k++) begin
            for (int i = 0; i < 6; i++) begin
                o = alu_op_e'(k);
                drive_instr(o, RES_NONE, va[i], vb[i], rand_bits(32), 1'b0);
                #1;
                check_eq("branch_taken_o", branch_taken, branch_model(o, va[i], vb[i]));
                check_eq("branch_target_o", branch_target, pc + imm);
                step();
            end
        end
        drive_instr(OP_B, RES_NONE, rand_bits(32), rand_bits(32), rand_bits(32), 1'b0);
        #1;
        check_eq("branch_taken_o", branch_taken, 1'b1);
        check_eq("branch_target_o", branch_target, pc + imm);
        step();
        drive_instr(OP_BL, RES_LINK, rand_bits(32), rand_bits(32), rand_bits(32), 1'b1);
        #1;
        check_eq("branch_taken_o", branch_taken, 1'b1);
        check_eq("branch_target_o", branch_target, pc + imm);
        check_result(pc + `EX_LINK_OFFSET);
        drive_instr(OP_JIRL, RES_LINK, rand_bits(32), rand_bits(32), rand_bits(32), 1'b1);
        #1;
        check_eq("branch_taken_o", branch_taken, 1'b1);
        check_eq("branch_target_o", branch_target, rs1_data + imm);
        check_result(pc + `EX_LINK_OFFSET);
        drive_instr(OP_BEQ, RES_NONE, 32'd9, 32'd9, 32'd16, 1'b0);
        valid = 1'b0;
        #1;
        check_eq("branch_taken_o", branch_taken, 1'b0);
        step();
    endtask

    task automatic run_divide(input alu_op_e o, input word_t a, input word_t b);
        drive_instr(o, RES_DIV, a, b, 32'd0, 1'b0);
        #1;
        check_eq("stall_req_o", stall_req, 1'b1);
        wait_div_done();
        check_result(div_model(o, a, b));
    endtask

    task automatic division_test();
        alu_op_e ops [4] = '{OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
        foreach (ops[i]) begin
            run_divide(ops[i], rand_bits(32), rand_bits(32));
            run_divide(ops[i], rand_bits(32), rand_bits(8) | 32'd1);
            run_divide(ops[i], 32'hffffff9c, 32'd7);
            run_divide(ops[i], 32'd100, 32'hfffffff9);
            run_divide(ops[i], rand_bits(32), 32'd0);
        end
    endtask

    task automatic stall_flush_test();
        word_t a, b, held;
        a = rand_bits(32);
        b = rand_bits(32);
        drive_instr(OP_XOR, RES_LOGIC, a, b, 32'd0, 1'b0);
        check_result(a ^ b);
        held = a ^ b;
        drive_instr(OP_ADD, RES_ARITH, a, b, 32'd0, 1'b0);
        stall = 1'b1;
        for (int i = 0; i < 3; i++) begin
            step();
            check_eq("res_wdata_o", res_wdata, held);
            check_eq("res_valid_o", res_valid, 1'b1);
        end
        stall = 1'b0;
        check_result(a + b);
        // Divide finishes while stalled and keeps its result
        held = a + b;
        drive_instr(OP_MOD, RES_DIV, a, b | 32'd3, 32'd0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            step();
        end
        stall = 1'b1;
        wait_div_done();
        for (int i = 0; i < 3; i++) begin
            step();
            check_eq("stall_req_o", stall_req, 1'b0);
            check_eq("res_valid_o", res_valid, 1'b0);
            check_eq("res_wdata_o", res_wdata, held);
        end
        stall = 1'b0;
        check_result(div_model(OP_MOD, a, b | 32'd3));
        drive_instr(OP_OR, RES_LOGIC, a, b, 32'd0, 1'b0);
        check_result(a | b);
        // OR stays presented while stalled
        stall = 1'b1;
        flush = 1'b1;
        step();
        check_eq("res_valid_o", res_valid, 1'b0);
        check_eq("res_wen_o", res_wen, 1'b0);
        flush = 1'b0;
        step();
        check_eq("res_valid_o", res_valid, 1'b0);
        stall = 1'b0;
        drive_instr(OP_AND, RES_LOGIC, a, b, 32'd0, 1'b0);
        flush = 1'b1;
        step();
        check_eq("res_valid_o", res_valid, 1'b0);
        flush = 1'b0;
        valid = 1'b0;
    endtask

    initial begin
        init_inputs();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_eq("res_valid_o", res_valid, 1'b0);
        alu_ops_test();
        forwarding_test();
        branch_test();
        division_test();
        stall_flush_test();
        step();
        $display("Checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, i_dut.u_chk.fail_count);
        if (errors == 0 && i_dut.u_chk.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/ex_stage_chk.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module ex_stage_chk (
    input logic           clk,
    input logic           rst,
    input logic           valid_i,
    input logic           stall_i,
    input logic           flush_i,
    input logic           branch_taken_o,
    input logic           stall_req_o,
    input logic           res_valid_o,
    input logic           res_wen_o,
    input ex_pkg::raddr_t res_waddr_o,
    input ex_pkg::word_t  res_wdata_o
);
    int fail_count;

    initial begin
        fail_count = 0;
    end

    a_clear: assert property (@(posedge clk) (rst || flush_i) |=> !res_valid_o)
        else begin
            fail_count++;
            $error("res_valid_o high in the cycle after reset or flush");
        end

    // Flush wins over stall
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (stall_i && !flush_i) |=> $stable(res_valid_o) && $stable(res_wen_o)
                                  && $stable(res_waddr_o) && $stable(res_wdata_o))
        else begin
            fail_count++;
            $error("Result outputs changed while stall_i was high");
        end

    a_taken: assert property (@(posedge clk) branch_taken_o |-> valid_i)
        else begin
            fail_count++;
            $error("branch_taken_o high without valid_i");
        end

    a_div_len: assert property (@(posedge clk) disable iff (rst)
        $rose(stall_req_o) |-> ##[1:`EX_XLEN+3] !stall_req_o)
        else begin
            fail_count++;
            $error("stall_req_o stayed high too long");
        end

endmodule

bind ex_stage ex_stage_chk u_chk (.*);

// ==== hdl/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_i,
    input  ex_pkg::alu_op_e   op_i,
    input  ex_pkg::res_sel_e  res_sel_i,
    input  ex_pkg::raddr_t    rs1_addr_i,
    input  ex_pkg::raddr_t    rs2_addr_i,
    input  ex_pkg::word_t     rs1_data_i,
    input  ex_pkg::word_t     rs2_data_i,
    input  ex_pkg::word_t     imm_i,
    input  ex_pkg::word_t     pc_i,
    input  logic              use_imm_i,
    input  ex_pkg::raddr_t    waddr_i,
    input  logic              wen_i,
    input  logic              fwd0_wen_i,
    input  logic              fwd0_load_i,
    input  ex_pkg::raddr_t    fwd0_addr_i,
    input  ex_pkg::word_t     fwd0_data_i,
    input  logic              fwd1_wen_i,
    input  logic              fwd1_load_i,
    input  ex_pkg::raddr_t    fwd1_addr_i,
    input  ex_pkg::word_t     fwd1_data_i,
    input  logic              stall_i,
    input  logic              flush_i,
    output logic              branch_taken_o,
    output ex_pkg::word_t     branch_target_o,
    output logic              stall_req_o,
    output logic              res_valid_o,
    output logic              res_wen_o,
    output ex_pkg::raddr_t    res_waddr_o,
    output ex_pkg::word_t     res_wdata_o
);
    import ex_pkg::*;

    word_t rs1_val;
    word_t rs2_val;
    word_t alu_result;
    word_t quotient;
    word_t remainder;
    logic  div_done;

    ex_operand_if opnd ();

    operand_select u_operand_select (
        .valid_i     (valid_i),
        .op_i        (op_i),
        .res_sel_i   (res_sel_i),
        .rs1_addr_i  (rs1_addr_i),
        .rs2_addr_i  (rs2_addr_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .imm_i       (imm_i),
        .pc_i        (pc_i),
        .use_imm_i   (use_imm_i),
        .waddr_i     (waddr_i),
        .wen_i       (wen_i),
        .fwd0_wen_i  (fwd0_wen_i),
        .fwd0_load_i (fwd0_load_i),
        .fwd0_addr_i (fwd0_addr_i),
        .fwd0_data_i (fwd0_data_i),
        .fwd1_wen_i  (fwd1_wen_i),
        .fwd1_load_i (fwd1_load_i),
        .fwd1_addr_i (fwd1_addr_i),
        .fwd1_data_i (fwd1_data_i),
        .rs1_val_o   (rs1_val),
        .rs2_val_o   (rs2_val),
        .opnd        (opnd)
    );

    alu u_alu (
        .opnd     (opnd),
        .result_o (alu_result)
    );

    branch_unit u_branch_unit (
        .opnd            (opnd),
        .rs1_val_i       (rs1_val),
        .rs2_val_i       (rs2_val),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o)
    );

    div_unit u_div_unit (
        .clk         (clk),
        .rst         (rst),
        .opnd        (opnd),
        .stall_i     (stall_i),
        .done_o      (div_done),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    result_buffer u_result_buffer (
        .clk          (clk),
        .rst          (rst),
        .opnd         (opnd),
        .alu_result_i (alu_result),
        .quotient_i   (quotient),
        .remainder_i  (remainder),
        .div_done_i   (div_done),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .stall_req_o  (stall_req_o),
        .res_valid_o  (res_valid_o),
        .res_wen_o    (res_wen_o),
        .res_waddr_o  (res_waddr_o),
        .res_wdata_o  (res_wdata_o)
    );

endmodule

// ==== hdl/result_buffer.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module result_buffer (
    input  logic            clk,
    input  logic            rst,
    ex_operand_if.sink      opnd,
    input  ex_pkg::word_t   alu_result_i,
    input  ex_pkg::word_t   quotient_i,
    input  ex_pkg::word_t   remainder_i,
    input  logic            div_done_i,
    input  logic            stall_i,
    input  logic            flush_i,
    output logic            stall_req_o,
    output logic            res_valid_o,
    output logic            res_wen_o,
    output ex_pkg::raddr_t  res_waddr_o,
    output ex_pkg::word_t   res_wdata_o
);
    import ex_pkg::*;

    logic  is_div;
    logic  take_quo;
    word_t wdata;

    assign is_div   = opnd.valid && (opnd.op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU});
    assign take_quo = (opnd.op == OP_DIV) || (opnd.op == OP_DIVU);

    // Hold upstream until the divider finishes
    assign stall_req_o = is_div && !div_done_i;

    always_comb begin
        case (opnd.res_sel)
            RES_LOGIC, RES_SHIFT, RES_ARITH, RES_MOVE: begin
                wdata = alu_result_i;
            end
            RES_LINK: begin
                wdata = opnd.pc + word_t'(`EX_LINK_OFFSET);
            end
            RES_DIV: begin
                wdata = take_quo ? quotient_i : remainder_i;
            end
            default: begin
                wdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            res_valid_o <= 1'b0;
            res_wen_o   <= 1'b0;
        end else if (!stall_i) begin
            // Bubble while a divide is still running
            res_valid_o <= opnd.valid && !stall_req_o;
            res_wen_o   <= opnd.valid && opnd.wen && !stall_req_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i && !stall_req_o) begin
            res_waddr_o <= opnd.waddr;
            res_wdata_o <= wdata;
        end
    end

endmodule

// ==== hdl/div_unit.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module div_unit (
    input  logic           clk,
    input  logic           rst,
    ex_operand_if.div      opnd,
    input  logic           stall_i,
    output logic           done_o,
    output ex_pkg::word_t  quotient_o,
    output ex_pkg::word_t  remainder_o
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(`EX_XLEN);

    div_state_e        state;
    logic [CNT_W-1:0]  count;
    logic              is_div;
    logic              is_signed;
    logic              start;
    logic              a_neg;
    logic              b_neg;
    word_t             a_mag;
    word_t             b_mag;
    word_t             quo;
    word_t             rem;
    word_t             dvs;
    logic              q_neg;
    logic              r_neg;
    logic              dvs_zero;
    logic [`EX_XLEN:0] trial;
    logic [`EX_XLEN:0] diff;

    assign is_div    = opnd.op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
    assign is_signed = (opnd.op == OP_DIV) || (opnd.op == OP_MOD);
    assign start     = (state == DIV_IDLE) && opnd.valid && is_div;

    // Operand magnitudes
    assign a_neg = is_signed && opnd.op1[`EX_XLEN-1];
    assign b_neg = is_signed && opnd.op2[`EX_XLEN-1];
    assign a_mag = a_neg ? -opnd.op1 : opnd.op1;
    assign b_mag = b_neg ? -opnd.op2 : opnd.op2;

    // One restoring step, diff MSB is the borrow
    assign trial = {rem, quo[`EX_XLEN-1]};
    assign diff  = trial - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DIV_IDLE;
            count <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state <= DIV_RUN;
                        count <= '0;
                    end
                end
                DIV_RUN: begin
                    count <= count + 1'b1;
                    if (count == CNT_W'(`EX_XLEN - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    if (!stall_i) begin
                        state <= DIV_IDLE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo      <= a_mag;
            rem      <= '0;
            dvs      <= b_mag;
            q_neg    <= a_neg ^ b_neg;
            r_neg    <= a_neg;
            dvs_zero <= (opnd.op2 == '0);
        end else if (state == DIV_RUN) begin
            // Dividend bits shift out as quotient bits shift in
            quo <= {quo[`EX_XLEN-2:0], ~diff[`EX_XLEN]};
            rem <= diff[`EX_XLEN] ? trial[`EX_XLEN-1:0] : diff[`EX_XLEN-1:0];
        end
    end

    assign done_o = (state == DIV_DONE);

    // Remainder already equals the dividend when the divisor is zero
    assign quotient_o  = dvs_zero ? '1 : (q_neg ? -quo : quo);
    assign remainder_o = r_neg ? -rem : rem;

endmodule

// ==== hdl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    ex_operand_if.br       opnd,
    input  ex_pkg::word_t  rs1_val_i,
    input  ex_pkg::word_t  rs2_val_i,
    output logic           branch_taken_o,
    output ex_pkg::word_t  branch_target_o
);
    import ex_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    // Compare on register values, never on the immediate
    assign eq   = (rs1_val_i == rs2_val_i);
    assign lt_s = ($signed(rs1_val_i) < $signed(rs2_val_i));
    assign lt_u = (rs1_val_i < rs2_val_i);

    always_comb begin
        case (opnd.op)
            OP_B, OP_BL, OP_JIRL: cond = 1'b1;
            OP_BEQ:               cond = eq;
            OP_BNE:               cond = !eq;
            OP_BLT:               cond = lt_s;
            OP_BGE:               cond = !lt_s;
            OP_BLTU:              cond = lt_u;
            OP_BGEU:              cond = !lt_u;
            default:              cond = 1'b0;
        endcase
    end

    assign branch_taken_o = opnd.valid && cond;

    // Register-relative target only for JIRL
    assign branch_target_o = (opnd.op == OP_JIRL) ? rs1_val_i + opnd.imm
                                                  : opnd.pc + opnd.imm;

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`include "ex_defs.svh"

module alu (
    ex_operand_if.alu      opnd,
    output ex_pkg::word_t  result_o
);
    import ex_pkg::*;

    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   sub;
    word_t                  addend;
    word_t                  sum;

    assign shamt = opnd.op2[`EX_SHAMT_W-1:0];

    // Shared adder for ADD and SUB
    assign sub    = (opnd.op == OP_SUB);
    assign addend = sub ? ~opnd.op2 : opnd.op2;
    assign sum    = opnd.op1 + addend + word_t'(sub);

    always_comb begin
        case (opnd.op)
            // Logic
            OP_OR: begin
                result_o = opnd.op1 | opnd.op2;
            end
            OP_AND: begin
                result_o = opnd.op1 & opnd.op2;
            end
            OP_XOR: begin
                result_o = opnd.op1 ^ opnd.op2;
            end
            OP_NOR: begin
                result_o = ~(opnd.op1 | opnd.op2);
            end
            OP_ORN: begin
                result_o = opnd.op1 | ~opnd.op2;
            end
            OP_ANDN: begin
                result_o = opnd.op1 & ~opnd.op2;
            end
            // Shift
            OP_SLL: begin
                result_o = opnd.op1 << shamt;
            end
            OP_SRL: begin
                result_o = opnd.op1 >> shamt;
            end
            OP_SRA: begin
                result_o = word_t'($signed(opnd.op1) >>> shamt);
            end
            // Arithmetic and compare
            OP_ADD, OP_SUB: begin
                result_o = sum;
            end
            OP_SLT: begin
                result_o = word_t'($signed(opnd.op1) < $signed(opnd.op2));
            end
            OP_SLTU: begin
                result_o = word_t'(opnd.op1 < opnd.op2);
            end
            // Move
            OP_LUI: begin
                result_o = opnd.op2;
            end
            OP_PCADD: begin
                result_o = opnd.pc + opnd.op2;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/operand_select.sv ====
`timescale 1ns/1ps

module operand_select (
    input  logic              valid_i,
    input  ex_pkg::alu_op_e   op_i,
    input  ex_pkg::res_sel_e  res_sel_i,
    input  ex_pkg::raddr_t    rs1_addr_i,
    input  ex_pkg::raddr_t    rs2_addr_i,
    input  ex_pkg::word_t     rs1_data_i,
    input  ex_pkg::word_t     rs2_data_i,
    input  ex_pkg::word_t     imm_i,
    input  ex_pkg::word_t     pc_i,
    input  logic              use_imm_i,
    input  ex_pkg::raddr_t    waddr_i,
    input  logic              wen_i,
    input  logic              fwd0_wen_i,
    input  logic              fwd0_load_i,
    input  ex_pkg::raddr_t    fwd0_addr_i,
    input  ex_pkg::word_t     fwd0_data_i,
    input  logic              fwd1_wen_i,
    input  logic              fwd1_load_i,
    input  ex_pkg::raddr_t    fwd1_addr_i,
    input  ex_pkg::word_t     fwd1_data_i,
    output ex_pkg::word_t     rs1_val_o,
    output ex_pkg::word_t     rs2_val_o,
    ex_operand_if.src         opnd
);
    import ex_pkg::*;

    logic hit0_rs1;
    logic hit1_rs1;
    logic hit0_rs2;
    logic hit1_rs2;

    // Only load data from a live write to a nonzero register
    function automatic logic fwd_hit(
        input logic   wen,
        input logic   load,
        input raddr_t faddr,
        input raddr_t saddr
    );
        return wen && load && (faddr == saddr) && (faddr != '0);
    endfunction

    assign hit0_rs1 = fwd_hit(fwd0_wen_i, fwd0_load_i, fwd0_addr_i, rs1_addr_i);
    assign hit1_rs1 = fwd_hit(fwd1_wen_i, fwd1_load_i, fwd1_addr_i, rs1_addr_i);
    assign hit0_rs2 = fwd_hit(fwd0_wen_i, fwd0_load_i, fwd0_addr_i, rs2_addr_i);
    assign hit1_rs2 = fwd_hit(fwd1_wen_i, fwd1_load_i, fwd1_addr_i, rs2_addr_i);

    // Port 1 is the younger entry
    assign rs1_val_o = hit1_rs1 ? fwd1_data_i :
                       hit0_rs1 ? fwd0_data_i : rs1_data_i;
    assign rs2_val_o = hit1_rs2 ? fwd1_data_i :
                       hit0_rs2 ? fwd0_data_i : rs2_data_i;

    assign opnd.valid   = valid_i;
    assign opnd.op      = op_i;
    assign opnd.res_sel = res_sel_i;
    assign opnd.op1     = rs1_val_o;
    assign opnd.op2     = use_imm_i ? imm_i : rs2_val_o;
    assign opnd.imm     = imm_i;
    assign opnd.pc      = pc_i;
    assign opnd.waddr   = waddr_i;
    assign opnd.wen     = wen_i;

endmodule

// ==== hdl/ex_operand_if.sv ====
`timescale 1ns/1ps

interface ex_operand_if;
    import ex_pkg::*;

    logic     valid;
    alu_op_e  op;
    res_sel_e res_sel;
    word_t    op1;
    word_t    op2;
    word_t    imm;
    word_t    pc;
    raddr_t   waddr;
    logic     wen;

    modport src (
        output valid, op, res_sel, op1, op2, imm, pc, waddr, wen
    );

    modport alu (
        input op, op1, op2, pc
    );

    modport br (
        input valid, op, imm, pc
    );

    modport div (
        input valid, op, op1, op2
    );

    modport sink (
        input valid, op, res_sel, pc, waddr, wen
    );

endinterface

// ==== hdl/ex_pkg.sv ====
`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] word_t;
    typedef logic [`EX_RADDR_W-1:0] raddr_t;

    typedef enum logic [5:0] {
        OP_NOP   = 6'd0,
        // Logic
        OP_OR    = 6'd1,
        OP_AND   = 6'd2,
        OP_XOR   = 6'd3,
        OP_NOR   = 6'd4,
        OP_ORN   = 6'd5,
        OP_ANDN  = 6'd6,
        // Shift
        OP_SLL   = 6'd7,
        OP_SRL   = 6'd8,
        OP_SRA   = 6'd9,
        // Arithmetic and compare
        OP_ADD   = 6'd10,
        OP_SUB   = 6'd11,
        OP_SLT   = 6'd12,
        OP_SLTU  = 6'd13,
        // Move
        OP_LUI   = 6'd14,
        OP_PCADD = 6'd15,
        // Branch and jump
        OP_B     = 6'd16,
        OP_BL    = 6'd17,
        OP_JIRL  = 6'd18,
        OP_BEQ   = 6'd19,
        OP_BNE   = 6'd20,
        OP_BLT   = 6'd21,
        OP_BGE   = 6'd22,
        OP_BLTU  = 6'd23,
        OP_BGEU  = 6'd24,
        // Divider
        OP_DIV   = 6'd25,
        OP_DIVU  = 6'd26,
        OP_MOD   = 6'd27,
        OP_MODU  = 6'd28
    } alu_op_e;

    typedef enum logic [2:0] {
        RES_NONE  = 3'd0,
        RES_LOGIC = 3'd1,
        RES_SHIFT = 3'd2,
        RES_ARITH = 3'd3,
        RES_MOVE  = 3'd4,
        RES_LINK  = 3'd5,
        RES_DIV   = 3'd6
    } res_sel_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

// ==== hdl/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Data path width
`define EX_XLEN 32

// Register file address width
`define EX_RADDR_W 5

// Shift amount bits taken from operand 2
`define EX_SHAMT_W 5

// Return address offset for BL and JIRL
`define EX_LINK_OFFSET 4

`endif
